//--- src/ecc_pkg.sv
package ecc_pkg;

    localparam int DATA_W   = 64;
    localparam int PARITY_W = 8;
    localparam int CODE_W   = DATA_W + PARITY_W;  // Codeword is {parity, data}
    localparam int POS_W    = $clog2(CODE_W);     // Bit index into a codeword
    localparam int CNT_W    = 16;
    localparam int APB_AW   = 6;
    localparam int APB_DW   = 32;

    // Byte offsets of the register map
    localparam logic [APB_AW-1:0] REG_CTRL     = 6'h00;
    localparam logic [APB_AW-1:0] REG_ADDR     = 6'h04;
    localparam logic [APB_AW-1:0] REG_WDATA_LO = 6'h08;
    localparam logic [APB_AW-1:0] REG_WDATA_HI = 6'h0C;
    localparam logic [APB_AW-1:0] REG_CMD      = 6'h10;
    localparam logic [APB_AW-1:0] REG_RDATA_LO = 6'h14;
    localparam logic [APB_AW-1:0] REG_RDATA_HI = 6'h18;
    localparam logic [APB_AW-1:0] REG_STATUS   = 6'h1C;
    localparam logic [APB_AW-1:0] REG_SBIT_CNT = 6'h20;
    localparam logic [APB_AW-1:0] REG_DBIT_CNT = 6'h24;
    localparam logic [APB_AW-1:0] REG_INJECT   = 6'h28;

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } cmd_op_e;

    typedef enum logic [1:0] {
        ERR_NONE   = 2'd0,
        ERR_SINGLE = 2'd1,
        ERR_DOUBLE = 2'd2
    } err_kind_e;

    typedef enum logic [2:0] {ST_IDLE, ST_WRITE, ST_READ, ST_CHECK, ST_SCRUB} ctrl_state_e;

endpackage

//--- src/ecc_secded.sv
`timescale 1ns/1ps

module ecc_secded (
    input  logic [ecc_pkg::DATA_W-1:0]   enc_data,
    input  logic [ecc_pkg::CODE_W-1:0]   chk_code,
    input  logic                         bypass,
    output logic [ecc_pkg::PARITY_W-1:0] enc_parity,
    output logic [ecc_pkg::DATA_W-1:0]   cor_data,
    output logic [ecc_pkg::PARITY_W-1:0] syndrome,
    output ecc_pkg::err_kind_e           err
);

    // Column i holds the check bits covering data bit i. All columns have odd weight,
    // so an even-weight syndrome can only come from a double error
    localparam logic [ecc_pkg::PARITY_W-1:0] H_COL [ecc_pkg::DATA_W] = '{
        8'h83, 8'h85, 8'h86, 8'h07, 8'h89, 8'h8A, 8'h0B, 8'h8C,
        8'h0D, 8'h0E, 8'h8F, 8'h91, 8'h92, 8'h13, 8'h94, 8'h15,
        8'h16, 8'h97, 8'h98, 8'h19, 8'h1A, 8'h9B, 8'h1C, 8'h9D,
        8'h9E, 8'h1F, 8'hA1, 8'hA2, 8'h23, 8'hA4, 8'h25, 8'h26,
        8'hA7, 8'hA8, 8'h29, 8'h2A, 8'hAB, 8'h2C, 8'hAD, 8'hAE,
        8'h2F, 8'hB0, 8'h31, 8'h32, 8'hB3, 8'h34, 8'hB5, 8'hB6,
        8'h37, 8'h38, 8'hB9, 8'hBA, 8'h3B, 8'hBC, 8'h3D, 8'h3E,
        8'hBF, 8'hC1, 8'hC2, 8'h43, 8'hC4, 8'h45, 8'h46, 8'hC7
    };

    logic [ecc_pkg::DATA_W-1:0] raw_data;
    logic [ecc_pkg::DATA_W-1:0] flip_mask;
    logic                       par_err;

    // Parity is the XOR of the columns of all set data bits
    function automatic logic [ecc_pkg::PARITY_W-1:0] calc_parity(
        input logic [ecc_pkg::DATA_W-1:0] d
    );
        logic [ecc_pkg::PARITY_W-1:0] p;
        p = '0;
        for (int i = 0; i < ecc_pkg::DATA_W; i++) begin
            if (d[i]) begin
                p = p ^ H_COL[i];
            end
        end
        return p;
    endfunction

    assign raw_data   = chk_code[ecc_pkg::DATA_W-1:0];
    assign enc_parity = calc_parity(enc_data);
    assign syndrome   = chk_code[ecc_pkg::CODE_W-1:ecc_pkg::DATA_W] ^ calc_parity(raw_data);

    // One set bit in the syndrome means a flipped check bit, data is intact
    assign par_err = (syndrome & (syndrome - 1'b1)) == '0;

    always_comb begin
        for (int i = 0; i < ecc_pkg::DATA_W; i++) begin
            flip_mask[i] = (syndrome == H_COL[i]);
        end
    end

    always_comb begin
        if (bypass) begin
            cor_data = raw_data;  // Raw view, no reporting
            err      = ecc_pkg::ERR_NONE;
        end else begin
            cor_data = raw_data ^ flip_mask;
            if (syndrome == '0) begin
                err = ecc_pkg::ERR_NONE;
            end else if ((|flip_mask) || par_err) begin
                err = ecc_pkg::ERR_SINGLE;
            end else begin
                err = ecc_pkg::ERR_DOUBLE;
            end
        end
    end

    // No two columns are equal so at most one data bit is ever flipped
    one_flip: assert final ($onehot0(flip_mask));

endmodule

//--- src/ecc_sram.sv
`timescale 1ns/1ps

module ecc_sram #(
    parameter int ADDR_W = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mem_we,
    input  logic                       mem_re,
    input  logic [ADDR_W-1:0]          mem_addr,
    input  logic [ecc_pkg::CODE_W-1:0] mem_wcode,
    output logic [ecc_pkg::CODE_W-1:0] mem_rcode
);

    logic [ecc_pkg::CODE_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wcode;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_rcode <= '0;
        end else if (mem_re) begin
            mem_rcode <= mem[mem_addr];  // Holds until the next read
        end
    end

    // Single port, the sequencer must never ask for both in one cycle
    we_re_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_we && mem_re));

endmodule

//--- src/ecc_ctrl.sv
`timescale 1ns/1ps

module ecc_ctrl #(
    parameter int ADDR_W = 6
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cmd_start,
    input  ecc_pkg::cmd_op_e             cmd_op,
    input  logic [ADDR_W-1:0]            cmd_addr,
    input  logic [ecc_pkg::DATA_W-1:0]   cmd_wdata,
    input  logic                         scrub_en,
    input  logic [ecc_pkg::POS_W-1:0]    inj_pos0,
    input  logic                         inj_en0,
    input  logic [ecc_pkg::POS_W-1:0]    inj_pos1,
    input  logic                         inj_en1,
    input  logic [ecc_pkg::PARITY_W-1:0] enc_parity,
    input  logic [ecc_pkg::DATA_W-1:0]   cor_data,
    input  logic [ecc_pkg::PARITY_W-1:0] syndrome,
    input  ecc_pkg::err_kind_e           err,
    input  logic [ecc_pkg::CODE_W-1:0]   mem_rcode,
    output logic                         cmd_done,
    output logic [ecc_pkg::DATA_W-1:0]   rd_data,
    output ecc_pkg::err_kind_e           rd_err,
    output logic [ecc_pkg::PARITY_W-1:0] rd_syndrome,
    output logic [ecc_pkg::CODE_W-1:0]   chk_code,
    output logic [ecc_pkg::DATA_W-1:0]   enc_data,
    output logic                         mem_we,
    output logic                         mem_re,
    output logic [ADDR_W-1:0]            mem_addr,
    output logic [ecc_pkg::CODE_W-1:0]   mem_wcode
);

    ecc_pkg::ctrl_state_e         state;
    ecc_pkg::ctrl_state_e         state_nxt;
    logic                         scrub_go;
    logic [ecc_pkg::DATA_W-1:0]   data_q;
    ecc_pkg::err_kind_e           err_q;
    logic [ecc_pkg::PARITY_W-1:0] syn_q;
    logic [ecc_pkg::CODE_W-1:0]   inj_mask;

    assign scrub_go = scrub_en && (err == ecc_pkg::ERR_SINGLE);

    always_comb begin
        state_nxt = state;
        case (state)
            ecc_pkg::ST_IDLE: begin
                if (cmd_start && cmd_op == ecc_pkg::OP_WRITE) begin
                    state_nxt = ecc_pkg::ST_WRITE;
                end else if (cmd_start && cmd_op == ecc_pkg::OP_READ) begin
                    state_nxt = ecc_pkg::ST_READ;
                end
            end
            ecc_pkg::ST_READ:  state_nxt = ecc_pkg::ST_CHECK;
            ecc_pkg::ST_CHECK: state_nxt = scrub_go ? ecc_pkg::ST_SCRUB : ecc_pkg::ST_IDLE;
            default:           state_nxt = ecc_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ecc_pkg::ST_IDLE;
            err_q <= ecc_pkg::ERR_NONE;
            syn_q <= '0;
        end else begin
            state <= state_nxt;
            if (state == ecc_pkg::ST_CHECK) begin
                err_q <= err;
                syn_q <= syndrome;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ecc_pkg::ST_CHECK) begin
            data_q <= cor_data;  // Also the write-back word for scrub
        end
    end

    // Test-only flips, positions past the codeword are ignored
    always_comb begin
        inj_mask = '0;
        if (inj_en0 && inj_pos0 < ecc_pkg::CODE_W) begin
            inj_mask[inj_pos0] = 1'b1;
        end
        if (inj_en1 && inj_pos1 < ecc_pkg::CODE_W) begin
            inj_mask[inj_pos1] = 1'b1;
        end
    end

    assign cmd_done = (state == ecc_pkg::ST_WRITE) || (state == ecc_pkg::ST_SCRUB) ||
                      (state == ecc_pkg::ST_CHECK && !scrub_go);

    // Results are live during the check cycle, held afterwards
    assign rd_data     = (state == ecc_pkg::ST_CHECK) ? cor_data : data_q;
    assign rd_err      = (state == ecc_pkg::ST_CHECK) ? err : err_q;
    assign rd_syndrome = (state == ecc_pkg::ST_CHECK) ? syndrome : syn_q;

    assign chk_code  = mem_rcode;
    assign enc_data  = (state == ecc_pkg::ST_SCRUB) ? data_q : cmd_wdata;
    assign mem_we    = (state == ecc_pkg::ST_WRITE) || (state == ecc_pkg::ST_SCRUB);
    assign mem_re    = (state == ecc_pkg::ST_READ);
    assign mem_addr  = cmd_addr;
    assign mem_wcode = {enc_parity, enc_data} ^ ((state == ecc_pkg::ST_WRITE) ? inj_mask : '0);

    // The front end holds off new commands while one is running
    start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start |-> state == ecc_pkg::ST_IDLE);

endmodule

//--- src/ecc_apb_regs.sv
`timescale 1ns/1ps

module ecc_apb_regs #(
    parameter int ADDR_W = 6
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [ecc_pkg::APB_AW-1:0]   paddr,
    input  logic [ecc_pkg::APB_DW-1:0]   pwdata,
    input  logic                         cmd_done,
    input  logic [ecc_pkg::DATA_W-1:0]   rd_data,
    input  ecc_pkg::err_kind_e           rd_err,
    input  logic [ecc_pkg::PARITY_W-1:0] rd_syndrome,
    output logic [ecc_pkg::APB_DW-1:0]   prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         bypass,
    output logic                         scrub_en,
    output logic                         cmd_start,
    output ecc_pkg::cmd_op_e             cmd_op,
    output logic [ADDR_W-1:0]            cmd_addr,
    output logic [ecc_pkg::DATA_W-1:0]   cmd_wdata,
    output logic [ecc_pkg::POS_W-1:0]    inj_pos0,
    output logic                         inj_en0,
    output logic [ecc_pkg::POS_W-1:0]    inj_pos1,
    output logic                         inj_en1
);

    logic                         access;
    logic                         cmd_go;
    logic                         bad_op;
    logic                         busy;
    logic                         mapped;
    logic                         read_only;
    logic                         wr_en;
    logic [ecc_pkg::DATA_W-1:0]   rdata_q;
    ecc_pkg::err_kind_e           err_q;
    logic [ecc_pkg::PARITY_W-1:0] syn_q;
    logic [ecc_pkg::CNT_W-1:0]    sbit_cnt;
    logic [ecc_pkg::CNT_W-1:0]    dbit_cnt;

    assign access = psel && penable;
    assign bad_op = pwrite && paddr == ecc_pkg::REG_CMD && pwdata[1:0] == 2'd3;
    // Decoded in the setup cycle so that cmd_start lands on the first access cycle
    assign cmd_go = psel && !penable && pwrite && paddr == ecc_pkg::REG_CMD &&
                    (pwdata[1:0] == ecc_pkg::OP_WRITE || pwdata[1:0] == ecc_pkg::OP_READ);

    assign pready  = !busy || cmd_done;
    assign pslverr = access && (!mapped || (pwrite && read_only) || bad_op);
    assign wr_en   = access && pready && pwrite && !pslverr;

    always_comb begin
        prdata    = '0;
        mapped    = 1'b1;
        read_only = 1'b0;
        case (paddr)
            ecc_pkg::REG_CTRL:     prdata[1:0] = {scrub_en, bypass};
            ecc_pkg::REG_ADDR:     prdata[ADDR_W-1:0] = cmd_addr;
            ecc_pkg::REG_WDATA_LO: prdata = cmd_wdata[ecc_pkg::APB_DW-1:0];
            ecc_pkg::REG_WDATA_HI: prdata = cmd_wdata[ecc_pkg::DATA_W-1:ecc_pkg::APB_DW];
            ecc_pkg::REG_CMD:      prdata[1:0] = cmd_op;
            ecc_pkg::REG_INJECT:   prdata[15:0] = {inj_en1, inj_pos1, inj_en0, inj_pos0};
            ecc_pkg::REG_RDATA_LO: begin
                prdata    = rdata_q[ecc_pkg::APB_DW-1:0];
                read_only = 1'b1;
            end
            ecc_pkg::REG_RDATA_HI: begin
                prdata    = rdata_q[ecc_pkg::DATA_W-1:ecc_pkg::APB_DW];
                read_only = 1'b1;
            end
            ecc_pkg::REG_STATUS: begin
                prdata[1:0]  = err_q;
                prdata[15:8] = syn_q;
                read_only    = 1'b1;
            end
            ecc_pkg::REG_SBIT_CNT: begin
                prdata[ecc_pkg::CNT_W-1:0] = sbit_cnt;
                read_only = 1'b1;
            end
            ecc_pkg::REG_DBIT_CNT: begin
                prdata[ecc_pkg::CNT_W-1:0] = dbit_cnt;
                read_only = 1'b1;
            end
            default: mapped = 1'b0;  // Reads back as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cmd_start <= 1'b0;
            cmd_op    <= ecc_pkg::OP_NONE;
            bypass    <= 1'b0;
            scrub_en  <= 1'b0;
            cmd_addr  <= '0;
            cmd_wdata <= '0;
            inj_pos0  <= '0;
            inj_en0   <= 1'b0;
            inj_pos1  <= '0;
            inj_en1   <= 1'b0;
            rdata_q   <= '0;
            err_q     <= ecc_pkg::ERR_NONE;
            syn_q     <= '0;
            sbit_cnt  <= '0;
            dbit_cnt  <= '0;
        end else begin
            cmd_start <= cmd_go;
            if (cmd_go) begin
                busy   <= 1'b1;
                cmd_op <= ecc_pkg::cmd_op_e'(pwdata[1:0]);
            end else if (cmd_done) begin
                busy <= 1'b0;
            end
            if (wr_en) begin
                case (paddr)
                    ecc_pkg::REG_CTRL: begin
                        bypass   <= pwdata[0];
                        scrub_en <= pwdata[1];
                    end
                    ecc_pkg::REG_ADDR:     cmd_addr <= pwdata[ADDR_W-1:0];
                    ecc_pkg::REG_WDATA_LO: cmd_wdata[ecc_pkg::APB_DW-1:0] <= pwdata;
                    ecc_pkg::REG_WDATA_HI: cmd_wdata[ecc_pkg::DATA_W-1:ecc_pkg::APB_DW] <= pwdata;
                    ecc_pkg::REG_INJECT: begin
                        inj_pos0 <= pwdata[ecc_pkg::POS_W-1:0];
                        inj_en0  <= pwdata[7];
                        inj_pos1 <= pwdata[8 +: ecc_pkg::POS_W];
                        inj_en1  <= pwdata[15];
                    end
                    default: ;
                endcase
            end
            if (cmd_done && cmd_op == ecc_pkg::OP_READ) begin
                rdata_q <= rd_data;
                err_q   <= rd_err;
                syn_q   <= rd_syndrome;
                if (rd_err == ecc_pkg::ERR_SINGLE && sbit_cnt != '1) begin
                    sbit_cnt <= sbit_cnt + 1'b1;
                end
                if (rd_err == ecc_pkg::ERR_DOUBLE && dbit_cnt != '1) begin
                    dbit_cnt <= dbit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- src/ecc_mem_top.sv
`timescale 1ns/1ps

module ecc_mem_top #(
    parameter int ADDR_W = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [ecc_pkg::APB_AW-1:0] paddr,
    input  logic [ecc_pkg::APB_DW-1:0] pwdata,
    output logic [ecc_pkg::APB_DW-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);

    // Names match the block ports one to one
    logic                         bypass;
    logic                         scrub_en;
    logic                         cmd_start;
    ecc_pkg::cmd_op_e             cmd_op;
    logic [ADDR_W-1:0]            cmd_addr;
    logic [ecc_pkg::DATA_W-1:0]   cmd_wdata;
    logic [ecc_pkg::POS_W-1:0]    inj_pos0;
    logic                         inj_en0;
    logic [ecc_pkg::POS_W-1:0]    inj_pos1;
    logic                         inj_en1;
    logic                         cmd_done;
    logic [ecc_pkg::DATA_W-1:0]   rd_data;
    ecc_pkg::err_kind_e           rd_err;
    logic [ecc_pkg::PARITY_W-1:0] rd_syndrome;
    logic [ecc_pkg::DATA_W-1:0]   enc_data;
    logic [ecc_pkg::PARITY_W-1:0] enc_parity;
    logic [ecc_pkg::CODE_W-1:0]   chk_code;
    logic [ecc_pkg::DATA_W-1:0]   cor_data;
    logic [ecc_pkg::PARITY_W-1:0] syndrome;
    ecc_pkg::err_kind_e           err;
    logic                         mem_we;
    logic                         mem_re;
    logic [ADDR_W-1:0]            mem_addr;
    logic [ecc_pkg::CODE_W-1:0]   mem_wcode;
    logic [ecc_pkg::CODE_W-1:0]   mem_rcode;

    ecc_apb_regs #(
        .ADDR_W(ADDR_W)
    ) u_regs (.*);

    ecc_ctrl #(
        .ADDR_W(ADDR_W)
    ) u_ctrl (.*);

    ecc_secded u_secded (.*);

    ecc_sram #(
        .ADDR_W(ADDR_W)
    ) u_sram (.*);

endmodule

//--- verification/tb_ecc_mem_top.sv
`timescale 1ns/1ps

module tb_ecc_mem_top;

    localparam int ADDR_W      = 6;
    localparam int APB_TIMEOUT = 20;
    localparam int MAX_CYCLES  = 20000;

    logic                       clk;
    logic                       rst_n;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [ecc_pkg::APB_AW-1:0] paddr;
    logic [ecc_pkg::APB_DW-1:0] pwdata;
    logic [ecc_pkg::APB_DW-1:0] prdata;
    logic                       pready;
    logic                       pslverr;

    logic [31:0] lfsr;
    int          err_cnt;
    int          test_errs;  // err_cnt when the current test started
    int          tests_ok;
    int          tests_bad;
    int          exp_sbit;
    int          exp_dbit;

    ecc_mem_top #(
        .ADDR_W(ADDR_W)
    ) uut (.*);

    always #5 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic int rand_pos();
        return int'(take_bits(7)) % ecc_pkg::CODE_W;
    endfunction

    function automatic logic [31:0] inj_word(input logic en0, input int pos0,
                                             input logic en1, input int pos1);
        return {16'h0, en1, 7'(pos1), en0, 7'(pos0)};
    endfunction

    task automatic check_data(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s data %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_err(input string what, input ecc_pkg::err_kind_e got,
                             input ecc_pkg::err_kind_e exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s err kind %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_syndrome(input string what, input logic [7:0] got,
                                  input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s syndrome %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s pslverr %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // Setup cycle, then access cycles until pready is seen at a rising edge
    task automatic apb_xfer(input logic wr, input logic [5:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        int waited;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        @(posedge clk);
        while (!pready && waited < APB_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (!pready) begin
            $display("APB transfer at offset %h never completed, pready stayed low", addr);
            err_cnt++;
        end
        rdata  = prdata;
        slverr = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [5:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        slverr;
        apb_xfer(1'b1, addr, data, unused, slverr);
        check_flag("write", slverr, 1'b0);
    endtask

    task automatic apb_read(input logic [5:0] addr, output logic [31:0] data);
        logic slverr;
        apb_xfer(1'b0, addr, 32'h0, data, slverr);
        check_flag("read", slverr, 1'b0);
    endtask

    task automatic write_word(input int addr, input logic [63:0] data, input logic [31:0] inj);
        apb_write(ecc_pkg::REG_ADDR, 32'(addr));
        apb_write(ecc_pkg::REG_WDATA_LO, data[31:0]);
        apb_write(ecc_pkg::REG_WDATA_HI, data[63:32]);
        apb_write(ecc_pkg::REG_INJECT, inj);
        apb_write(ecc_pkg::REG_CMD, 32'(ecc_pkg::OP_WRITE));
    endtask

    task automatic read_word(input int addr, output logic [63:0] data,
                             output ecc_pkg::err_kind_e kind);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] st;
        apb_write(ecc_pkg::REG_ADDR, 32'(addr));
        apb_write(ecc_pkg::REG_CMD, 32'(ecc_pkg::OP_READ));
        apb_read(ecc_pkg::REG_RDATA_LO, lo);
        apb_read(ecc_pkg::REG_RDATA_HI, hi);
        apb_read(ecc_pkg::REG_STATUS, st);
        data = {hi, lo};
        kind = ecc_pkg::err_kind_e'(st[1:0]);
    endtask

    // Reads and checks one word, the counter model follows the expected kind
    task automatic expect_read(input string what, input int addr, input logic [63:0] exp,
                               input ecc_pkg::err_kind_e exp_kind);
        logic [63:0]        data;
        ecc_pkg::err_kind_e kind;
        read_word(addr, data, kind);
        check_data(what, data, exp);
        check_err(what, kind, exp_kind);
        if (exp_kind == ecc_pkg::ERR_SINGLE) exp_sbit++;
    endtask

    // STATUS still holds the result of the last read command
    task automatic expect_syndrome(input string what, input logic [7:0] exp);
        logic [31:0] st;
        apb_read(ecc_pkg::REG_STATUS, st);
        check_syndrome(what, st[15:8], exp);
    endtask

    task automatic check_counts();
        logic [31:0] cnt;
        apb_read(ecc_pkg::REG_SBIT_CNT, cnt);
        check_count("SBIT_CNT", cnt[15:0], 16'(exp_sbit));
        apb_read(ecc_pkg::REG_DBIT_CNT, cnt);
        check_count("DBIT_CNT", cnt[15:0], 16'(exp_dbit));
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == test_errs) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d check(s) failed", name, err_cnt - test_errs);
            tests_bad++;
        end
        test_errs = err_cnt;
    endtask

    task automatic test_clean();
        logic [63:0] words [4];
        for (int i = 0; i < 4; i++) begin
            words[i] = take_bits(64);
            write_word(i * 9 + 1, words[i], 32'h0);
        end
        for (int i = 0; i < 4; i++) begin
            expect_read("clean", i * 9 + 1, words[i], ecc_pkg::ERR_NONE);
            expect_syndrome("clean", 8'h00);
        end
        check_counts();
    endtask

    task automatic test_single();
        logic [63:0] w;
        int          pos;
        for (int i = 0; i < 4; i++) begin
            w   = take_bits(64);
            pos = (i == 0) ? 64 + int'(take_bits(3)) : rand_pos();  // First one hits parity
            write_word(32 + i, w, inj_word(1'b1, pos, 1'b0, 0));
            expect_read("single", 32 + i, w, ecc_pkg::ERR_SINGLE);
            if (pos >= ecc_pkg::DATA_W) begin
                expect_syndrome("single parity", 8'h01 << (pos - ecc_pkg::DATA_W));
            end
        end
        check_counts();
    endtask

    task automatic test_double();
        logic [63:0]        w;
        logic [63:0]        data;
        ecc_pkg::err_kind_e kind;
        int                 p0;
        int                 p1;
        for (int i = 0; i < 3; i++) begin
            w  = take_bits(64);
            p0 = rand_pos();
            p1 = (p0 + 1 + int'(take_bits(6))) % ecc_pkg::CODE_W;  // Never equal to p0
            write_word(40 + i, w, inj_word(1'b1, p0, 1'b1, p1));
            read_word(40 + i, data, kind);
            check_err("double", kind, ecc_pkg::ERR_DOUBLE);
            exp_dbit++;
        end
        check_counts();
    endtask

    task automatic test_bypass();
        logic [63:0]        w;
        logic [63:0]        data;
        ecc_pkg::err_kind_e kind;
        int                 k;
        w = take_bits(64);
        k = int'(take_bits(6));
        write_word(44, w, inj_word(1'b1, k, 1'b0, 0));
        apb_write(ecc_pkg::REG_CTRL, 32'h1);
        read_word(44, data, kind);
        check_data("bypass", data, w ^ (64'd1 << k));
        check_err("bypass", kind, ecc_pkg::ERR_NONE);
        apb_write(ecc_pkg::REG_CTRL, 32'h0);
        check_counts();
    endtask

    task automatic test_scrub();
        logic [63:0] w;
        w = take_bits(64);
        apb_write(ecc_pkg::REG_CTRL, 32'h2);
        write_word(48, w, inj_word(1'b1, rand_pos(), 1'b0, 0));
        expect_read("scrub first", 48, w, ecc_pkg::ERR_SINGLE);
        expect_read("scrub second", 48, w, ecc_pkg::ERR_NONE);
        expect_syndrome("scrub second", 8'h00);
        apb_write(ecc_pkg::REG_CTRL, 32'h0);
        w = take_bits(64);
        write_word(49, w, inj_word(1'b1, rand_pos(), 1'b0, 0));
        expect_read("no scrub first", 49, w, ecc_pkg::ERR_SINGLE);
        expect_read("no scrub second", 49, w, ecc_pkg::ERR_SINGLE);
        check_counts();
    endtask

    task automatic test_slverr();
        logic [31:0] rd;
        logic        serr;
        logic [63:0] w;
        apb_xfer(1'b1, ecc_pkg::REG_CMD, 32'h3, rd, serr);
        check_flag("CMD value 3", serr, 1'b1);
        apb_xfer(1'b0, 6'h30, 32'h0, rd, serr);
        check_flag("offset 0x30", serr, 1'b1);
        check_data("offset 0x30", 64'(rd), 64'h0);
        apb_xfer(1'b1, ecc_pkg::REG_STATUS, 32'h1, rd, serr);
        check_flag("STATUS write", serr, 1'b1);
        w = take_bits(64);
        write_word(7, w, 32'h0);
        expect_read("after slverr", 7, w, ecc_pkg::ERR_NONE);
        check_counts();
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Simulation hit its limit of %0d cycles before the tests finished", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lfsr      = 32'ha8c9_00e5;
        err_cnt   = 0;
        test_errs = 0;
        tests_ok  = 0;
        tests_bad = 0;
        exp_sbit  = 0;
        exp_dbit  = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_clean();
        finish_test("clean_round_trip");
        test_single();
        finish_test("single_bit_correction");
        test_double();
        finish_test("double_bit_detection");
        test_bypass();
        finish_test("bypass");
        test_scrub();
        finish_test("scrub");
        test_slverr();
        finish_test("slave_errors");

        $display("%0d tests ok, %0d tests with errors, %0d failed checks",
                 tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- ecc_mem_top.f
src/ecc_pkg.sv
src/ecc_secded.sv
src/ecc_sram.sv
src/ecc_ctrl.sv
src/ecc_apb_regs.sv
src/ecc_mem_top.sv
verification/tb_ecc_mem_top.sv

//--- Bender.yml
package:
  name: ecc_mem

sources:
  - files:
      - src/ecc_pkg.sv
      - src/ecc_secded.sv
      - src/ecc_sram.sv
      - src/ecc_ctrl.sv
      - src/ecc_apb_regs.sv
      - src/ecc_mem_top.sv
  - target: test
    files:
      - verification/tb_ecc_mem_top.sv
